// File: eeprom_sys.f
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/eeprom_arbiter.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_wr.sv
verilog/eeprom_sys.sv
test/eeprom_model.sv
test/tb_eeprom_sys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the eeprom_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f eeprom_sys.f --top-module tb_eeprom_sys -o sim_eeprom_sys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_eeprom_sys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0

// File: test/tb_eeprom_sys.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module tb_eeprom_sys;

    localparam int NUM_XFERS = 50;
    localparam int READ_BITS = 41; // scl periods of 4 bytes plus two starts and a stop
    localparam int WATCHDOG_NS = NUM_XFERS * READ_BITS * 2 * `EE_SCL_HALF * 10 * 2 + 2000;

    logic        CLK;
    logic        RESET;
    logic        wr_0;
    logic        rd_0;
    logic [10:0] addr_0;
    logic [7:0]  wdata_0;
    logic        ack_0;
    logic [7:0]  rdata_0;
    logic        wr_1;
    logic        rd_1;
    logic [10:0] addr_1;
    logic [7:0]  wdata_1;
    logic        ack_1;
    logic [7:0]  rdata_1;
    logic        scl;
    logic        sda_oe;
    logic        model_oe;
    wire         sda;

    logic        pend_wr [2];
    logic [10:0] pend_addr [2];
    logic [7:0]  pend_data [2];
    int          issued [2];
    int          acked [2];
    logic [7:0]  shadow [2048];
    logic        written [2048];
    int          ack_order [$];
    int          cmp_errors;
    int          cmp_checks;
    int          seq_errors;
    int          seq_checks;
    logic [31:0] seed;

    assign sda = ~(sda_oe | model_oe); // wired-and with pull-up

    eeprom_sys u_eeprom_sys (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_0    (wr_0),
        .rd_0    (rd_0),
        .addr_0  (addr_0),
        .wdata_0 (wdata_0),
        .ack_0   (ack_0),
        .rdata_0 (rdata_0),
        .wr_1    (wr_1),
        .rd_1    (rd_1),
        .addr_1  (addr_1),
        .wdata_1 (wdata_1),
        .ack_1   (ack_1),
        .rdata_1 (rdata_1),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    eeprom_model u_model (
        .scl    (scl),
        .sda    (sda),
        .sda_oe (model_oe)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected read value is the last write or else the initial fill
    function automatic logic [7:0] ref_read(input logic [10:0] a);
        if (written[a])
            return shadow[a];
        return a[7:0] ^ {5'b0, a[10:8]};
    endfunction

    task automatic take_ack(input int c, input logic [7:0] got);
        logic [7:0] exp;
        ack_order.push_back(c);
        cmp_checks++;
        if (issued[c] == acked[c])
        begin
            cmp_errors++;
            $display("ack seen on client %0d with no transfer outstanding", c);
        end
        else
        begin
            if (pend_wr[c])
            begin
                shadow[pend_addr[c]] = pend_data[c];
                written[pend_addr[c]] = 1'b1;
            end
            else
            begin
                exp = ref_read(pend_addr[c]);
                if (got !== exp)
                begin
                    cmp_errors++;
                    $display("FAILED rdata_%0d: got %h expected %h at addr %h",
                             c, got, exp, pend_addr[c]);
                end
            end
            acked[c]++;
        end
    endtask

    // acks are sampled mid-cycle
    initial
    begin
        for (int i = 0; i < 2048; i++)
            written[i] = 1'b0;
        acked[0] = 0;
        acked[1] = 0;
        cmp_errors = 0;
        cmp_checks = 0;
        forever
        begin
            @(negedge CLK);
            if (RESET === 1'b0)
            begin
                if (ack_0 === 1'b1)
                    take_ack(0, rdata_0);
                if (ack_1 === 1'b1)
                    take_ack(1, rdata_1);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, transfers did not complete in time");
        $display("Result: FAILED");
        $finish;
    end

    task automatic apply_reset();
        @(posedge CLK);
        #1;
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
    endtask

    task automatic set_client(input int c, input logic w, input logic [10:0] a,
                              input logic [7:0] d);
        pend_wr[c] = w;
        pend_addr[c] = a;
        pend_data[c] = d;
        issued[c]++;
        if (c == 0)
        begin
            wr_0 = w;
            rd_0 = !w;
            addr_0 = a;
            wdata_0 = d;
        end
        else
        begin
            wr_1 = w;
            rd_1 = !w;
            addr_1 = a;
            wdata_1 = d;
        end
    endtask

    task automatic drop_strobes();
        @(posedge CLK);
        #1;
        wr_0 = 1'b0;
        rd_0 = 1'b0;
        wr_1 = 1'b0;
        rd_1 = 1'b0;
    endtask

    task automatic request(input int c, input logic w, input logic [10:0] a,
                           input logic [7:0] d);
        @(posedge CLK);
        #1;
        set_client(c, w, a, d);
        drop_strobes();
    endtask

    task automatic wait_client(input int c);
        while (issued[c] != acked[c])
            @(posedge CLK);
    endtask

    task automatic check_order(input int base, input int first_c, input int second_c);
        seq_checks++;
        if (ack_order.size() != base + 2 || ack_order[base] != first_c
            || ack_order[base + 1] != second_c)
        begin
            seq_errors++;
            $display("acks came in the wrong order, expected client %0d then client %0d",
                     first_c, second_c);
        end
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        int now_err;
        now_err = seq_errors + cmp_errors;
        if (now_err == mark)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d error(s)", num, name, now_err - mark);
    endtask

    initial
    begin
        int          c;
        logic        w;
        logic [10:0] a;
        logic [7:0]  d;
        logic [10:0] last_a;
        int          base;
        int          mark;
        RESET = 1'b1;
        wr_0 = 1'b0;
        rd_0 = 1'b0;
        addr_0 = '0;
        wdata_0 = '0;
        wr_1 = 1'b0;
        rd_1 = 1'b0;
        addr_1 = '0;
        wdata_1 = '0;
        issued[0] = 0;
        issued[1] = 0;
        seq_errors = 0;
        seq_checks = 0;
        seed = 32'h20ef;
        last_a = 11'h0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        mark = seq_errors + cmp_errors;
        repeat (20)
        begin
            @(negedge CLK);
            seq_checks++;
            if (scl !== 1'b1 || sda_oe !== 1'b0 || ack_0 !== 1'b0 || ack_1 !== 1'b0)
            begin
                seq_errors++;
                $display("FAILED idle: scl %h sda_oe %h ack_0 %h ack_1 %h",
                         scl, sda_oe, ack_0, ack_1);
            end
        end
        report_test(1, "idle after reset", mark);

        mark = seq_errors + cmp_errors;
        request(0, 1'b0, 11'h000, 8'h00);
        wait_client(0);
        request(0, 1'b0, 11'h123, 8'h00);
        wait_client(0);
        request(0, 1'b0, 11'h4ff, 8'h00);
        wait_client(0);
        request(0, 1'b0, 11'h7a5, 8'h00);
        wait_client(0);
        report_test(2, "initial fill reads", mark);

        mark = seq_errors + cmp_errors;
        base = ack_order.size();
        request(1, 1'b1, 11'h6c3, 8'h5a);
        wait_client(1);
        request(1, 1'b0, 11'h6c3, 8'h00);
        wait_client(1);
        seq_checks++;
        if (ack_order.size() != base + 2 || ack_order[base] != 1
            || ack_order[base + 1] != 1)
        begin
            seq_errors++;
            $display("acks during the client 1 transfers did not go to client 1 alone");
        end
        report_test(3, "write then read", mark);

        mark = seq_errors + cmp_errors;
        apply_reset();
        base = ack_order.size();
        @(posedge CLK);
        #1;
        set_client(0, 1'b0, 11'h2a1, 8'h00);
        set_client(1, 1'b1, 11'h315, 8'hc3);
        drop_strobes();
        wait_client(0);
        wait_client(1);
        check_order(base, 0, 1);
        base = ack_order.size();
        @(posedge CLK);
        #1;
        set_client(0, 1'b1, 11'h0f0, 8'h96);
        set_client(1, 1'b0, 11'h315, 8'h00);
        drop_strobes();
        wait_client(0);
        wait_client(1);
        check_order(base, 1, 0);
        report_test(4, "round-robin priority", mark);

        mark = seq_errors + cmp_errors;
        for (int n = 0; n < 40; n++)
        begin
            seed = lcg(seed);
            c = int'(seed[16]);
            w = seed[17];
            a = seed[28:18];
            d = seed[15:8];
            if (seed[3] && n > 0)
                a = last_a; // revisit a written address now and then
            if (w)
                last_a = a;
            wait_client(c);
            request(c, w, a, d);
        end
        wait_client(0);
        wait_client(1);
        report_test(5, "random mixed transfers", mark);

        $display("checks %0d, errors %0d", seq_checks + cmp_checks, seq_errors + cmp_errors);
        if (seq_errors + cmp_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: test/eeprom_model.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,
    output logic sda_oe // 1 pulls sda low
);

    localparam int DEPTH = 1 << `EE_ADDR_W;

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_SEND} mstate_t;

    logic [7:0]            mem [DEPTH];
    mstate_t               state;
    logic [3:0]            cnt; // scl rising edges in the current byte
    logic [7:0]            shreg;
    logic [7:0]            tx;
    logic [2:0]            blk;
    logic [`EE_ADDR_W-1:0] ptr;
    logic                  first;
    logic                  scl_q;
    logic                  sda_q;
    shift_byte_u           rx;

    initial
    begin
        logic [10:0] av;
        for (int a = 0; a < DEPTH; a++)
        begin
            av = 11'(a);
            mem[a] = av[7:0] ^ {5'b0, av[10:8]}; // initial fill
        end
        state = M_IDLE;
        cnt = 4'd0;
        sda_oe = 1'b0;
        first = 1'b0;
        ptr = '0;
        blk = 3'd0;
        scl_q = 1'b1;
        sda_q = 1'b1;
    end

    task automatic take_byte();
        rx.raw = shreg;
        case (state)
            M_CTRL:
            begin
                if (rx.ctrl.dev == `EE_DEV_CODE)
                begin
                    sda_oe = 1'b1;
                    blk = rx.ctrl.blk;
                    if (rx.ctrl.rnw)
                    begin
                        tx = mem[ptr]; // random read at the dummy-write address
                        state = M_SEND;
                        first = 1'b1;
                    end
                    else
                        state = M_ADDR;
                end
                else
                    state = M_IDLE; // not addressed
            end
            M_ADDR:
            begin
                ptr = {blk, rx.raw};
                sda_oe = 1'b1;
                state = M_WDATA;
            end
            default:
            begin
                mem[ptr] = rx.raw;
                ptr = ptr + 1'b1;
                sda_oe = 1'b1;
            end
        endcase
    endtask

    task automatic scl_fall();
        if (state != M_IDLE)
        begin
            if (cnt == 4'd8 && state != M_SEND)
                take_byte();
            else if (cnt == 4'd9)
            begin
                sda_oe = 1'b0;
                cnt = 4'd0;
                if (state == M_SEND)
                begin
                    if (first)
                    begin
                        first = 1'b0;
                        sda_oe = ~tx[7];
                        tx = {tx[6:0], 1'b0};
                    end
                    else
                        state = M_IDLE; // one byte, then nack and stop
                end
            end
            else if (state == M_SEND)
            begin
                if (cnt == 4'd8)
                    sda_oe = 1'b0; // master ack slot
                else
                begin
                    sda_oe = ~tx[7];
                    tx = {tx[6:0], 1'b0};
                end
            end
        end
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            if (sda === 1'b0)
            begin
                state = M_CTRL; // start or repeated start
                cnt = 4'd0;
            end
            else
            begin
                state = M_IDLE; // stop
                sda_oe = 1'b0;
            end
        end
        else if (scl === 1'b1 && scl_q === 1'b0)
        begin
            if (state != M_IDLE)
            begin
                if (cnt < 4'd8 && state != M_SEND)
                    shreg = {shreg[6:0], sda};
                cnt = cnt + 4'd1;
            end
        end
        else if (scl === 1'b0 && scl_q === 1'b1)
            scl_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: verilog/eeprom_sys.sv
`timescale 1ns/1ns

module eeprom_sys
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr_0,
    input  logic        rd_0,
    input  logic [10:0] addr_0,
    input  logic [7:0]  wdata_0,
    output logic        ack_0,
    output logic [7:0]  rdata_0,
    input  logic        wr_1,
    input  logic        rd_1,
    input  logic [10:0] addr_1,
    input  logic [7:0]  wdata_1,
    output logic        ack_1,
    output logic [7:0]  rdata_1,
    output logic        scl,
    output logic        sda_oe,  // 1 pulls sda low
    input  logic        sda_in
);

    mem_req_t   req;
    logic       req_valid;
    logic       busy;
    logic       done;
    logic [7:0] seq_rdata;
    bus_cmd_t   cmd;
    logic       cmd_valid;
    logic       cmd_done;
    logic [7:0] rx_byte;

    eeprom_arbiter u_arbiter (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr_0      (wr_0),
        .rd_0      (rd_0),
        .addr_0    (addr_0),
        .wdata_0   (wdata_0),
        .wr_1      (wr_1),
        .rd_1      (rd_1),
        .addr_1    (addr_1),
        .wdata_1   (wdata_1),
        .busy      (busy),
        .done      (done),
        .rdata     (seq_rdata),
        .req       (req),
        .req_valid (req_valid),
        .ack_0     (ack_0),
        .ack_1     (ack_1),
        .rdata_0   (rdata_0),
        .rdata_1   (rdata_1)
    );

    eeprom_wr u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .busy      (busy),
        .done      (done),
        .rdata     (seq_rdata),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    i2c_bit_engine u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sda_in    (sda_in),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

// File: verilog/eeprom_wr.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module eeprom_wr
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  mem_req_t   req,
    input  logic       req_valid,
    input  logic       cmd_done,
    input  logic [7:0] rx_byte,
    output logic       busy,
    output logic       done,
    output logic [7:0] rdata,
    output bus_cmd_t   cmd,
    output logic       cmd_valid
);

    // one-hot main states
    localparam logic [9:0] S_IDLE     = 10'b00_0000_0001;
    localparam logic [9:0] S_WR_START = 10'b00_0000_0010;
    localparam logic [9:0] S_CTRL_WR  = 10'b00_0000_0100;
    localparam logic [9:0] S_ADDR_WR  = 10'b00_0000_1000;
    localparam logic [9:0] S_DATA_WR  = 10'b00_0001_0000;
    localparam logic [9:0] S_RD_START = 10'b00_0010_0000;
    localparam logic [9:0] S_CTRL_RD  = 10'b00_0100_0000;
    localparam logic [9:0] S_DATA_RD  = 10'b00_1000_0000;
    localparam logic [9:0] S_STOP     = 10'b01_0000_0000;
    localparam logic [9:0] S_ACKN     = 10'b10_0000_0000;

    logic [9:0] state;
    logic       sent; // command of this state already out
    mem_req_t   cur;
    bus_cmd_t   next_cmd;

    assign busy = (state != S_IDLE);

    always_comb
    begin
        next_cmd.op = OP_WRITE_BYTE;
        next_cmd.data.raw = cur.addr[7:0];
        next_cmd.last = 1'b0;
        case (state)
            S_WR_START, S_RD_START: next_cmd.op = OP_START;
            S_CTRL_WR, S_CTRL_RD:
            begin
                next_cmd.data.ctrl.dev = `EE_DEV_CODE;
                next_cmd.data.ctrl.blk = cur.addr[10:8];
                next_cmd.data.ctrl.rnw = (state == S_CTRL_RD);
            end
            S_DATA_WR: next_cmd.data.raw = cur.wdata;
            S_DATA_RD:
            begin
                next_cmd.op = OP_READ_BYTE;
                next_cmd.last = 1'b1; // single byte, nack it
            end
            S_STOP: next_cmd.op = OP_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= S_IDLE;
            sent <= 1'b0;
            cmd_valid <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    done <= 1'b0;
                    if (req_valid)
                        state <= S_WR_START; // both kinds open with a write header
                end
                S_ACKN:
                begin
                    done <= 1'b0;
                    state <= S_IDLE;
                end
                default:
                begin
                    if (!sent)
                    begin
                        cmd_valid <= 1'b1;
                        sent <= 1'b1;
                    end
                    else if (cmd_done)
                    begin
                        sent <= 1'b0;
                        case (state)
                            S_WR_START: state <= S_CTRL_WR;
                            S_CTRL_WR:  state <= S_ADDR_WR;
                            S_ADDR_WR:  state <= cur.wr ? S_DATA_WR : S_RD_START;
                            S_DATA_WR:  state <= S_STOP;
                            S_RD_START: state <= S_CTRL_RD;
                            S_CTRL_RD:  state <= S_DATA_RD;
                            S_DATA_RD:  state <= S_STOP;
                            S_STOP:
                            begin
                                state <= S_ACKN;
                                done <= 1'b1;
                            end
                            default:    state <= S_IDLE;
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && req_valid)
            cur <= req;
        if (!sent)
            cmd <= next_cmd;
        if (state == S_DATA_RD && cmd_done)
            rdata <= rx_byte;
    end

endmodule

// File: verilog/i2c_bit_engine.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bus_cmd_t   cmd,
    input  logic       cmd_valid,
    input  logic       sda_in,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       scl,
    output logic       sda_oe
);

    localparam int HALF = `EE_SCL_HALF;
    localparam int CW = $clog2(HALF);

    logic          running;
    bus_op_t       op;
    logic          last;
    logic [7:0]    tx;
    logic [CW-1:0] hcnt; // cycle within a half period
    logic [4:0]    hidx; // half period within the command
    logic [4:0]    end_idx;
    logic          is_byte;
    logic          half_end;
    logic          drive_now;
    logic          drv;

    // start and stop: low, high, high
    // bytes: low then high for each of the 9 bits
    function automatic logic half_scl(input bus_op_t o, input logic [4:0] idx);
        if (o == OP_WRITE_BYTE || o == OP_READ_BYTE)
            return idx[0];
        return idx != 5'd0;
    endfunction

    assign is_byte = (op == OP_WRITE_BYTE) || (op == OP_READ_BYTE);
    assign end_idx = is_byte ? 5'd17 : 5'd2;
    assign half_end = running && (hcnt == CW'(HALF - 1));

    // sda moves one cycle after scl, and only while scl is low on bytes
    assign drive_now = running && (hcnt == '0) && (!is_byte || !hidx[0]);

    always_comb
    begin
        case (op)
            OP_START:      drv = (hidx == 5'd2); // falls with scl high
            OP_STOP:       drv = (hidx != 5'd2); // rises with scl high
            OP_WRITE_BYTE: drv = (hidx < 5'd16) ? ~tx[7] : 1'b0; // release for ack
            default:       drv = (hidx >= 5'd16) && !last;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            running <= 1'b0;
            cmd_done <= 1'b0;
            scl <= 1'b1;
            sda_oe <= 1'b0;
            hcnt <= '0;
            hidx <= '0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (cmd_valid && !running)
            begin
                running <= 1'b1;
                hcnt <= '0;
                hidx <= '0;
                scl <= half_scl(cmd.op, 5'd0);
            end
            else if (running)
            begin
                if (drive_now)
                    sda_oe <= drv;
                if (half_end)
                begin
                    hcnt <= '0;
                    if (hidx == end_idx)
                    begin
                        running <= 1'b0; // scl left high
                        cmd_done <= 1'b1;
                    end
                    else
                    begin
                        hidx <= hidx + 5'd1;
                        scl <= half_scl(op, hidx + 5'd1);
                    end
                end
                else
                    hcnt <= hcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && !running)
        begin
            op <= cmd.op;
            last <= cmd.last;
            tx <= cmd.data.raw;
        end
        else if (drive_now && op == OP_WRITE_BYTE && hidx < 5'd16)
            tx <= {tx[6:0], 1'b0}; // msb first
        // sample at the end of scl high, slave ack is not checked
        if (half_end && op == OP_READ_BYTE && hidx[0] && hidx < 5'd16)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

// File: verilog/eeprom_arbiter.sv
`timescale 1ns/1ns
`include "eeprom_defs.svh"

module eeprom_arbiter
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr_0,
    input  logic        rd_0,
    input  logic [10:0] addr_0,
    input  logic [7:0]  wdata_0,
    input  logic        wr_1,
    input  logic        rd_1,
    input  logic [10:0] addr_1,
    input  logic [7:0]  wdata_1,
    input  logic        busy,
    input  logic        done,
    input  logic [7:0]  rdata,
    output mem_req_t    req,
    output logic        req_valid,
    output logic        ack_0,
    output logic        ack_1,
    output logic [7:0]  rdata_0,
    output logic [7:0]  rdata_1
);

    logic [`EE_NUM_CLIENTS-1:0] strobe;
    logic [`EE_NUM_CLIENTS-1:0] pend_valid;
    logic [`EE_NUM_CLIENTS-1:0] cand;
    mem_req_t in_req [`EE_NUM_CLIENTS];
    mem_req_t pend_req [`EE_NUM_CLIENTS];
    mem_req_t cand_req [`EE_NUM_CLIENTS];
    logic prio;
    logic grant_idx;
    logic in_flight;
    logic sel;
    logic issue;

    assign strobe = {wr_1 | rd_1, wr_0 | rd_0};
    assign in_req[0] = '{wr: wr_0, addr: addr_0, wdata: wdata_0}; // wr wins over rd
    assign in_req[1] = '{wr: wr_1, addr: addr_1, wdata: wdata_1};

    // a fresh strobe can go out in the same cycle it is latched
    always_comb
    begin
        for (int i = 0; i < `EE_NUM_CLIENTS; i++)
        begin
            cand[i] = pend_valid[i] | strobe[i];
            cand_req[i] = pend_valid[i] ? pend_req[i] : in_req[i];
        end
        sel = cand[prio] ? prio : ~prio;
        issue = !busy && !in_flight && (|cand);
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend_valid <= '0;
            prio <= 1'b0;
            grant_idx <= 1'b0;
            in_flight <= 1'b0;
            req_valid <= 1'b0;
            ack_0 <= 1'b0;
            ack_1 <= 1'b0;
        end
        else
        begin
            req_valid <= issue;
            ack_0 <= done && !grant_idx;
            ack_1 <= done && grant_idx;
            for (int i = 0; i < `EE_NUM_CLIENTS; i++)
                if (strobe[i])
                    pend_valid[i] <= 1'b1;
            if (issue)
            begin
                in_flight <= 1'b1;
                grant_idx <= sel;
                if (&cand)
                    prio <= ~sel; // rival waited, it goes first next time
            end
            if (done)
            begin
                in_flight <= 1'b0;
                pend_valid[grant_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < `EE_NUM_CLIENTS; i++)
            if (strobe[i] && !pend_valid[i])
                pend_req[i] <= in_req[i];
        if (issue)
            req <= cand_req[sel];
        if (done && !grant_idx)
            rdata_0 <= rdata;
        if (done && grant_idx)
            rdata_1 <= rdata;
    end

endmodule

// File: verilog/eeprom_pkg.sv
`include "eeprom_defs.svh"

package eeprom_pkg;

    // one client request
    typedef struct packed {
        logic                  wr;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE_BYTE,
        OP_READ_BYTE
    } bus_op_t;

    typedef struct packed {
        logic [3:0] dev;
        logic [2:0] blk; // address bits 10..8
        logic       rnw;
    } ctrl_view_t;

    // byte on the wire, plain or as a control byte
    typedef union packed {
        logic [7:0] raw;
        ctrl_view_t ctrl;
    } shift_byte_u;

    typedef struct packed {
        bus_op_t     op;
        shift_byte_u data;
        logic        last; // read: send nack
    } bus_cmd_t;

endpackage

// File: verilog/eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// CLK cycles per SCL half period, 2 or more
`define EE_SCL_HALF 4

// 24C16 style device code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

`define EE_ADDR_W 11 // byte address, 2K bytes

`define EE_NUM_CLIENTS 2

`endif
